//--- hw/wh_test_pkg.sv
/*
  Shared definitions for the wormhole link tester
  Header field widths, flit header layout, counter width, controller states
*/
`default_nettype none

package wh_test_pkg;

  // Header fields, coordinate sits in the lowest bits of a flit
  localparam int cord_width_c = 5;
  localparam int len_width_c  = 3;
  localparam int hdr_width_c  = cord_width_c + len_width_c;

  // Sent and received packet counters
  localparam int count_width_c = 32;

  // Flit header, cord is the low field
  typedef struct packed {
    logic [len_width_c-1:0]  len;
    logic [cord_width_c-1:0] cord;
  } wh_hdr_s;

  // Traffic controller run states
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN,
    DONE
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- hw/wh_data_gen.sv
/*
  Per-channel data sequence generator
  Index advances on each consumed item, channel c shows index plus c
*/
`timescale 1ns/100ps
`default_nettype none

module wh_data_gen
  #(parameter int num_channels_p  = 2
   ,parameter int channel_width_p = 8
  )
  (input  logic                                      clk_i
  ,input  logic                                      reset_i
  ,input  logic                                      clear_i
  ,input  logic                                      yumi_i
  ,output logic [num_channels_p*channel_width_p-1:0] data_o
  );

  logic [channel_width_p-1:0] index_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i || clear_i)
      index_r <= '0;
    else if (yumi_i)
      index_r <= index_r + 1'b1;
  end

  // Offset per channel so lanes of the payload differ
  for (genvar c = 0; c < num_channels_p; c++)
  begin : chan
    assign data_o[c*channel_width_p +: channel_width_p] = index_r + channel_width_p'(c);
  end

endmodule

`default_nettype wire

//--- hw/wh_one_fifo.sv
/*
  One-entry flit buffer
  ready_and handshake on the input, yumi consumption on the output
*/
`timescale 1ns/100ps
`default_nettype none

module wh_one_fifo
  #(parameter int flit_width_p = 32
  )
  (input  logic                    clk_i
  ,input  logic                    reset_i

  ,input  logic                    v_i
  ,input  logic [flit_width_p-1:0] data_i
  ,output logic                    ready_and_o

  ,output logic                    v_o
  ,output logic [flit_width_p-1:0] data_o
  ,input  logic                    yumi_i
  );

  logic                    full_r;
  logic [flit_width_p-1:0] data_r;
  logic                    enq;

  // Empty, or emptied this cycle
  assign ready_and_o = ~full_r | yumi_i;
  assign enq         = v_i & ready_and_o;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      full_r <= 1'b0;
    else if (enq)
      full_r <= 1'b1;
    else if (yumi_i)
      full_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
      data_r <= data_i;
  end

  assign v_o    = full_r;
  assign data_o = data_r;

endmodule

`default_nettype wire

//--- hw/wh_test_master.sv
/*
  Test master for one lane
  Packet source, looped-back response checker, sent and received counters
*/
`timescale 1ns/100ps
`default_nettype none

module wh_test_master
  import wh_test_pkg::*;
  #(parameter int num_channels_p  = 2
   ,parameter int channel_width_p = 8
   ,parameter int flit_width_p    = 32
  )
  (input  logic                     clk_i
  ,input  logic                     reset_i
  ,input  logic                     clear_i
  ,input  logic                     en_i
  ,input  logic [cord_width_c-1:0]  dest_cord_i

  // Forward link
  ,output logic                     fwd_v_o
  ,output logic [flit_width_p-1:0]  fwd_data_o
  ,input  logic                     fwd_ready_and_i

  // Return link
  ,input  logic                     ret_v_i
  ,input  logic [flit_width_p-1:0]  ret_data_i
  ,output logic                     ret_ready_and_o

  ,output logic [count_width_c-1:0] sent_count_o
  ,output logic [count_width_c-1:0] received_count_o
  ,output logic                     error_o
  );

  localparam int payload_width_lp = num_channels_p * channel_width_p;

  wh_hdr_s                     req_hdr;
  logic                        req_ready_and;
  logic [flit_width_p-1:0]     req_data;
  logic                        req_send;
  logic                        resp_v;
  logic [flit_width_p-1:0]     resp_data;
  logic [payload_width_lp-1:0] data_gen;
  logic [payload_width_lp-1:0] data_check;

  // Single-flit packets only
  assign req_hdr.cord = dest_cord_i;
  assign req_hdr.len  = '0;
  assign req_data     = flit_width_p'({data_gen, req_hdr});
  assign req_send     = en_i & req_ready_and;

  wh_one_fifo #(.flit_width_p(flit_width_p)) req_out_fifo
    (.clk_i      (clk_i)
    ,.reset_i    (reset_i)
    ,.v_i        (en_i)
    ,.data_i     (req_data)
    ,.ready_and_o(req_ready_and)
    ,.v_o        (fwd_v_o)
    ,.data_o     (fwd_data_o)
    ,.yumi_i     (fwd_v_o & fwd_ready_and_i)
    );

  // Responses are taken as soon as they show up
  wh_one_fifo #(.flit_width_p(flit_width_p)) resp_in_fifo
    (.clk_i      (clk_i)
    ,.reset_i    (reset_i)
    ,.v_i        (ret_v_i)
    ,.data_i     (ret_data_i)
    ,.ready_and_o(ret_ready_and_o)
    ,.v_o        (resp_v)
    ,.data_o     (resp_data)
    ,.yumi_i     (resp_v)
    );

  wh_data_gen
    #(.num_channels_p (num_channels_p)
     ,.channel_width_p(channel_width_p)
    ) gen_out
    (.clk_i  (clk_i)
    ,.reset_i(reset_i)
    ,.clear_i(clear_i)
    ,.yumi_i (req_send)
    ,.data_o (data_gen)
    );

  // Local copy of the sequence to check echoes against
  wh_data_gen
    #(.num_channels_p (num_channels_p)
     ,.channel_width_p(channel_width_p)
    ) gen_check
    (.clk_i  (clk_i)
    ,.reset_i(reset_i)
    ,.clear_i(clear_i)
    ,.yumi_i (resp_v)
    ,.data_o (data_check)
    );

  always_ff @(posedge clk_i)
  begin
    if (reset_i || clear_i)
    begin
      sent_count_o     <= '0;
      received_count_o <= '0;
      error_o          <= 1'b0;
    end
    else
    begin
      if (req_send)
        sent_count_o <= sent_count_o + 1'b1;
      if (resp_v)
        received_count_o <= received_count_o + 1'b1;
      // Sticky until the next clear
      if (resp_v && (resp_data[hdr_width_c +: payload_width_lp] != data_check))
        error_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/wh_loopback_node.sv
/*
  Loopback node for one lane
  Buffers each flit, checks its coordinate, echoes it or flags a misroute
*/
`timescale 1ns/100ps
`default_nettype none

module wh_loopback_node
  import wh_test_pkg::*;
  #(parameter int flit_width_p = 32
   ,parameter int home_cord_p  = 5
  )
  (input  logic                    clk_i
  ,input  logic                    reset_i
  ,input  logic                    clear_i
  ,input  logic                    stall_i

  ,input  logic                    in_v_i
  ,input  logic [flit_width_p-1:0] in_data_i
  ,output logic                    in_ready_and_o

  ,output logic                    out_v_o
  ,output logic [flit_width_p-1:0] out_data_o
  ,input  logic                    out_ready_and_i

  ,output logic                    misroute_o
  );

  wh_hdr_s in_hdr;
  logic    home_match;
  logic    buf_v;
  logic    buf_yumi;

  assign in_hdr     = in_data_i[hdr_width_c-1:0];
  assign home_match = (in_hdr.cord == cord_width_c'(home_cord_p));

  // Stall hides the buffered flit, so nothing drains
  assign out_v_o  = buf_v & ~stall_i;
  assign buf_yumi = out_v_o & out_ready_and_i;

  // Foreign flits are accepted but never written
  wh_one_fifo #(.flit_width_p(flit_width_p)) echo_buf
    (.clk_i      (clk_i)
    ,.reset_i    (reset_i)
    ,.v_i        (in_v_i & home_match)
    ,.data_i     (in_data_i)
    ,.ready_and_o(in_ready_and_o)
    ,.v_o        (buf_v)
    ,.data_o     (out_data_o)
    ,.yumi_i     (buf_yumi)
    );

  always_ff @(posedge clk_i)
  begin
    if (reset_i || clear_i)
      misroute_o <= 1'b0;
    else if (in_v_i && in_ready_and_o && !home_match)
      misroute_o <= 1'b1;
  end

endmodule

`default_nettype wire

//--- hw/wh_traffic_ctrl.sv
/*
  Traffic controller FSM
  Latches budget and lane mask, enables lanes until each reaches its budget
*/
`timescale 1ns/100ps
`default_nettype none

module wh_traffic_ctrl
  import wh_test_pkg::*;
  #(parameter int num_lanes_p = 2
  )
  (input  logic                                      clk_i
  ,input  logic                                      reset_i
  ,input  logic                                      start_i
  ,input  logic [count_width_c-1:0]                  budget_i
  ,input  logic [num_lanes_p-1:0]                    lane_mask_i
  ,input  logic [num_lanes_p-1:0][count_width_c-1:0] sent_count_i
  ,input  logic                                      all_done_i
  ,output logic [num_lanes_p-1:0]                    en_o
  ,output logic                                      clear_o
  );

  ctrl_state_e              state_r;
  ctrl_state_e              state_n;
  logic [count_width_c-1:0] budget_r;
  logic [num_lanes_p-1:0]   mask_r;
  logic                     start_ok;

  // A stuck DRAIN, e.g. after a misroute, can be restarted too
  assign start_ok = start_i & (state_r != RUN);
  assign clear_o  = start_ok;

  // Drops the same cycle the count hits the budget
  for (genvar i = 0; i < num_lanes_p; i++)
  begin : lane
    assign en_o[i] = (state_r == RUN) & mask_r[i] & (sent_count_i[i] < budget_r);
  end

  always_comb
  begin
    state_n = state_r;
    if (start_ok)
      state_n = RUN;
    else
    begin
      case (state_r)
        RUN:     if (~|en_o) state_n = DRAIN;
        DRAIN:   if (all_done_i) state_n = DONE;
        default: state_n = state_r;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= IDLE;
      mask_r  <= '0;
    end
    else
    begin
      state_r <= state_n;
      if (start_ok)
        mask_r <= lane_mask_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (start_ok)
      budget_r <= budget_i;
  end

endmodule

`default_nettype wire

//--- hw/wh_status_collect.sv
/*
  Status collector
  Registered sent and received totals, per-lane flags, test completion
*/
`timescale 1ns/100ps
`default_nettype none

module wh_status_collect
  import wh_test_pkg::*;
  #(parameter int num_lanes_p = 2
  )
  (input  logic                                      clk_i
  ,input  logic                                      reset_i
  ,input  logic [num_lanes_p-1:0]                    lane_mask_i
  ,input  logic [count_width_c-1:0]                  budget_i
  ,input  logic [num_lanes_p-1:0][count_width_c-1:0] sent_count_i
  ,input  logic [num_lanes_p-1:0][count_width_c-1:0] received_count_i
  ,input  logic [num_lanes_p-1:0]                    error_i
  ,input  logic [num_lanes_p-1:0]                    misroute_i
  ,output logic [count_width_c-1:0]                  sent_total_o
  ,output logic [count_width_c-1:0]                  received_total_o
  ,output logic [num_lanes_p-1:0]                    error_o
  ,output logic [num_lanes_p-1:0]                    misroute_o
  ,output logic                                      all_done_o
  );

  logic [count_width_c-1:0] sent_sum;
  logic [count_width_c-1:0] received_sum;
  logic                     lanes_done;

  always_comb
  begin
    sent_sum     = '0;
    received_sum = '0;
    // No lane masked means no test running
    lanes_done   = |lane_mask_i;
    for (int i = 0; i < num_lanes_p; i++)
    begin
      sent_sum     = sent_sum + sent_count_i[i];
      received_sum = received_sum + received_count_i[i];
      if (lane_mask_i[i] &&
          ((sent_count_i[i] != budget_i) || (received_count_i[i] != budget_i)))
        lanes_done = 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      sent_total_o     <= '0;
      received_total_o <= '0;
      all_done_o       <= 1'b0;
    end
    else
    begin
      sent_total_o     <= sent_sum;
      received_total_o <= received_sum;
      all_done_o       <= lanes_done;
    end
  end

  assign error_o    = error_i;
  assign misroute_o = misroute_i;

endmodule

`default_nettype wire

//--- hw/wh_test_top.sv
/*
  Wormhole link tester top level
  Traffic controller, per-lane master and loopback pairs, status collector
*/
`timescale 1ns/100ps
`default_nettype none

module wh_test_top
  import wh_test_pkg::*;
  #(parameter int num_lanes_p     = 2
   ,parameter int num_channels_p  = 2
   ,parameter int channel_width_p = 8
   ,parameter int flit_width_p    = 32
   ,parameter int home_cord_p     = 5
  )
  (input  logic                     clk_i
  ,input  logic                     reset_i
  ,input  logic                     start_i
  ,input  logic [count_width_c-1:0] budget_i
  ,input  logic [num_lanes_p-1:0]   lane_mask_i
  ,input  logic [num_lanes_p-1:0]   stall_i
  ,input  logic [cord_width_c-1:0]  dest_cord_i
  ,output logic                     done_o
  ,output logic [num_lanes_p-1:0]   error_o
  ,output logic [num_lanes_p-1:0]   misroute_o
  ,output logic [count_width_c-1:0] sent_total_o
  ,output logic [count_width_c-1:0] received_total_o
  );

  logic [num_lanes_p-1:0]                    en;
  logic                                      clear;
  logic [num_lanes_p-1:0][count_width_c-1:0] sent_count;
  logic [num_lanes_p-1:0][count_width_c-1:0] received_count;
  logic [num_lanes_p-1:0]                    lane_error;
  logic [num_lanes_p-1:0]                    lane_misroute;

  wh_traffic_ctrl #(.num_lanes_p(num_lanes_p)) ctrl
    (.clk_i       (clk_i)
    ,.reset_i     (reset_i)
    ,.start_i     (start_i)
    ,.budget_i    (budget_i)
    ,.lane_mask_i (lane_mask_i)
    ,.sent_count_i(sent_count)
    ,.all_done_i  (done_o)
    ,.en_o        (en)
    ,.clear_o     (clear)
    );

  for (genvar i = 0; i < num_lanes_p; i++)
  begin : lane
    logic                    fwd_v;
    logic [flit_width_p-1:0] fwd_data;
    logic                    fwd_ready_and;
    logic                    ret_v;
    logic [flit_width_p-1:0] ret_data;
    logic                    ret_ready_and;

    wh_test_master
      #(.num_channels_p (num_channels_p)
       ,.channel_width_p(channel_width_p)
       ,.flit_width_p   (flit_width_p)
      ) master
      (.clk_i           (clk_i)
      ,.reset_i         (reset_i)
      ,.clear_i         (clear)
      ,.en_i            (en[i])
      ,.dest_cord_i     (dest_cord_i)
      ,.fwd_v_o         (fwd_v)
      ,.fwd_data_o      (fwd_data)
      ,.fwd_ready_and_i (fwd_ready_and)
      ,.ret_v_i         (ret_v)
      ,.ret_data_i      (ret_data)
      ,.ret_ready_and_o (ret_ready_and)
      ,.sent_count_o    (sent_count[i])
      ,.received_count_o(received_count[i])
      ,.error_o         (lane_error[i])
      );

    wh_loopback_node
      #(.flit_width_p(flit_width_p)
       ,.home_cord_p (home_cord_p)
      ) loopback
      (.clk_i          (clk_i)
      ,.reset_i        (reset_i)
      ,.clear_i        (clear)
      ,.stall_i        (stall_i[i])
      ,.in_v_i         (fwd_v)
      ,.in_data_i      (fwd_data)
      ,.in_ready_and_o (fwd_ready_and)
      ,.out_v_o        (ret_v)
      ,.out_data_o     (ret_data)
      ,.out_ready_and_i(ret_ready_and)
      ,.misroute_o     (lane_misroute[i])
      );
  end

  wh_status_collect #(.num_lanes_p(num_lanes_p)) status
    (.clk_i           (clk_i)
    ,.reset_i         (reset_i)
    ,.lane_mask_i     (lane_mask_i)
    ,.budget_i        (budget_i)
    ,.sent_count_i    (sent_count)
    ,.received_count_i(received_count)
    ,.error_i         (lane_error)
    ,.misroute_i      (lane_misroute)
    ,.sent_total_o    (sent_total_o)
    ,.received_total_o(received_total_o)
    ,.error_o         (error_o)
    ,.misroute_o      (misroute_o)
    ,.all_done_o      (done_o)
    );

endmodule

`default_nettype wire

//--- verif/tb_wh_test.sv
/*
  Testbench for the wormhole link tester
  Clean, back-pressured, partial-mask, misrouted and restarted runs
*/
`timescale 1ns/100ps
`default_nettype none

module tb_wh_test
  import wh_test_pkg::*;
  ();

  localparam int num_lanes_lp = 2;
  localparam int home_cord_lp = 5;
  localparam int budget_lp    = 20;
  localparam int timeout_lp   = 2000;

  logic                     clk_i;
  logic                     reset_i;
  logic                     start_i;
  logic [count_width_c-1:0] budget_i;
  logic [num_lanes_lp-1:0]  lane_mask_i;
  logic [num_lanes_lp-1:0]  stall_i;
  logic [cord_width_c-1:0]  dest_cord_i;
  logic                     done_o;
  logic [num_lanes_lp-1:0]  error_o;
  logic [num_lanes_lp-1:0]  misroute_o;
  logic [count_width_c-1:0] sent_total_o;
  logic [count_width_c-1:0] received_total_o;

  // Phase state seen by the assertions
  logic        started;
  logic        misroute_ok;
  logic        done_armed;
  logic        done_allowed;
  logic [31:0] expected_total;
  logic [31:0] rng_state;

  wh_test_top dut0
    (.clk_i           (clk_i)
    ,.reset_i         (reset_i)
    ,.start_i         (start_i)
    ,.budget_i        (budget_i)
    ,.lane_mask_i     (lane_mask_i)
    ,.stall_i         (stall_i)
    ,.dest_cord_i     (dest_cord_i)
    ,.done_o          (done_o)
    ,.error_o         (error_o)
    ,.misroute_o      (misroute_o)
    ,.sent_total_o    (sent_total_o)
    ,.received_total_o(received_total_o)
    );

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    stop_with_error($sformatf("Mismatch at %0t: %s is %0h, expected %0h",
                              $time, name, got, exp));
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
      report_mismatch(name, got, exp);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int lanes_in_mask(input logic [num_lanes_lp-1:0] mask);
    int n;
    n = 0;
    for (int i = 0; i < num_lanes_lp; i++)
      n += int'(mask[i]);
    return n;
  endfunction

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // Quiet until the first start
  a_idle_done: assert property (@(posedge clk_i) disable iff (reset_i)
    !started |-> done_o == 1'b0)
    else report_mismatch("done_o", $sampled(done_o), 0);
  a_idle_sent: assert property (@(posedge clk_i) disable iff (reset_i)
    !started |-> sent_total_o == '0)
    else report_mismatch("sent_total_o", $sampled(sent_total_o), 0);
  a_idle_received: assert property (@(posedge clk_i) disable iff (reset_i)
    !started |-> received_total_o == '0)
    else report_mismatch("received_total_o", $sampled(received_total_o), 0);

  // No corrupted data is ever injected
  a_no_error: assert property (@(posedge clk_i) disable iff (reset_i)
    error_o == '0)
    else report_mismatch("error_o", $sampled(error_o), 0);
  a_no_misroute: assert property (@(posedge clk_i) disable iff (reset_i)
    !misroute_ok |-> misroute_o == '0)
    else report_mismatch("misroute_o", $sampled(misroute_o), 0);

  a_order: assert property (@(posedge clk_i) disable iff (reset_i)
    received_total_o <= sent_total_o)
    else stop_with_error($sformatf("Received total %0d ran ahead of sent total %0d at %0t",
                                   $sampled(received_total_o), $sampled(sent_total_o), $time));

  a_done_sent: assert property (@(posedge clk_i) disable iff (reset_i)
    done_armed && done_o |-> sent_total_o == expected_total)
    else report_mismatch("sent_total_o", $sampled(sent_total_o), $sampled(expected_total));
  a_done_received: assert property (@(posedge clk_i) disable iff (reset_i)
    done_armed && done_o |-> received_total_o == expected_total)
    else report_mismatch("received_total_o", $sampled(received_total_o),
                         $sampled(expected_total));
  a_no_done: assert property (@(posedge clk_i) disable iff (reset_i)
    done_armed && !done_allowed |-> !done_o)
    else stop_with_error($sformatf("done_o rose during a misrouted run at %0t", $time));
  a_done_held: assert property (@(posedge clk_i) disable iff (reset_i)
    done_armed && $past(done_o) |-> done_o)
    else stop_with_error($sformatf("done_o fell before the next start at %0t", $time));

  task automatic start_run(input logic [num_lanes_lp-1:0] mask,
                           input logic [cord_width_c-1:0] cord,
                           input logic expect_misroute);
    done_armed     = 1'b0;
    done_allowed   = !expect_misroute;
    started        = 1'b1;
    expected_total = lanes_in_mask(mask) * budget_lp;
    lane_mask_i    = mask;
    budget_i       = budget_lp;
    dest_cord_i    = cord;
    start_i        = 1'b1;
    next_cycle();
    start_i     = 1'b0;
    misroute_ok = expect_misroute;
    // Totals show the cleared counts one cycle after the start edge
    next_cycle();
    check_value("sent_total_o", sent_total_o, 0);
    check_value("received_total_o", received_total_o, 0);
    next_cycle();
    done_armed = 1'b1;
  endtask

  task automatic wait_for_done(input logic random_stall);
    int cycles;
    cycles = 0;
    while (!done_o && cycles < timeout_lp)
    begin
      if (random_stall)
      begin
        rng_state = xorshift32(rng_state);
        stall_i   = rng_state[num_lanes_lp-1:0];
      end
      next_cycle();
      cycles++;
    end
    stall_i = '0;
    if (!done_o)
      stop_with_error("Timed out waiting for done_o to rise");
  endtask

  task automatic wait_for_misroute(input logic [num_lanes_lp-1:0] mask);
    int cycles;
    cycles = 0;
    while (misroute_o != mask && cycles < timeout_lp)
    begin
      next_cycle();
      cycles++;
    end
    if (misroute_o != mask)
      stop_with_error("Timed out waiting for misroute_o on the enabled lanes");
  endtask

  task automatic wait_for_sent_total(input logic [31:0] total);
    int cycles;
    cycles = 0;
    while (sent_total_o != total && cycles < timeout_lp)
    begin
      next_cycle();
      cycles++;
    end
    if (sent_total_o != total)
      stop_with_error("Timed out waiting for the sent total to reach the budget");
  endtask

  task automatic run_clean(input logic [num_lanes_lp-1:0] mask, input logic random_stall);
    start_run(mask, cord_width_c'(home_cord_lp), 1'b0);
    wait_for_done(random_stall);
    // A few more cycles so the held done is watched too
    repeat (4) next_cycle();
    check_value("done_o", done_o, 1);
    check_value("sent_total_o", sent_total_o, expected_total);
    check_value("received_total_o", received_total_o, expected_total);
    check_value("error_o", error_o, 0);
    check_value("misroute_o", misroute_o, 0);
  endtask

  task automatic run_misrouted(input logic [num_lanes_lp-1:0] mask);
    start_run(mask, cord_width_c'(home_cord_lp - 2), 1'b1);
    wait_for_misroute(mask);
    wait_for_sent_total(expected_total);
    // Dropped flits never come back
    repeat (40)
    begin
      next_cycle();
      check_value("received_total_o", received_total_o, 0);
    end
    check_value("done_o", done_o, 0);
  endtask

  initial
  begin
    reset_i        = 1'b1;
    start_i        = 1'b0;
    budget_i       = '0;
    lane_mask_i    = '0;
    stall_i        = '0;
    dest_cord_i    = '0;
    started        = 1'b0;
    misroute_ok    = 1'b0;
    done_armed     = 1'b0;
    done_allowed   = 1'b1;
    expected_total = '0;
    rng_state      = 32'hfc5c_6425;
    repeat (8) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    repeat (10) next_cycle();
    check_value("done_o", done_o, 0);
    check_value("sent_total_o", sent_total_o, 0);

    run_clean(2'b11, 1'b0);
    run_clean(2'b11, 1'b1);
    run_clean(2'b01, 1'b0);
    run_misrouted(2'b11);
    // Restart with the home coordinate after the stuck run
    run_clean(2'b11, 1'b1);

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
hw/wh_test_pkg.sv
hw/wh_data_gen.sv
hw/wh_one_fifo.sv
hw/wh_test_master.sv
hw/wh_loopback_node.sv
hw/wh_traffic_ctrl.sv
hw/wh_status_collect.sv
hw/wh_test_top.sv
verif/tb_wh_test.sv

//--- run_sim.sh
#!/bin/sh
# Build the wormhole link tester with Verilator, run it and check the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_wh_test -o tb_wh_test \
  && ./obj_dir/tb_wh_test > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log

grep -q "Finished with no errors" sim.log \
  || { echo "Pass message not found in sim.log"; exit 1; }
